/* vec_pkg.sv */
`default_nettype none

package vec_pkg;

    // register geometry
    localparam int VLEN       = 64;
    localparam int ELEM_W     = 16;
    localparam int NUM_LANES  = VLEN / ELEM_W;
    localparam int NUM_VEC    = 32;
    localparam int REG_ADDR_W = 5;
    localparam int INSN_W     = 32;

    // major opcodes
    localparam logic [6:0] OPC_LOAD  = 7'h07;
    localparam logic [6:0] OPC_STORE = 7'h27;
    localparam logic [6:0] OPC_VALU  = 7'h57;

    // minor codes, funct3 field
    localparam logic [2:0] MNR_VV = 3'h0;
    localparam logic [2:0] MNR_VI = 3'h3;

    // funct6 codes
    localparam logic [5:0] F6_ADD = 6'h00;
    localparam logic [5:0] F6_SUB = 6'h02;
    localparam logic [5:0] F6_AND = 6'h09;
    localparam logic [5:0] F6_OR  = 6'h0A;
    localparam logic [5:0] F6_XOR = 6'h0B;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_ALU,
        KIND_LOAD,
        KIND_STORE
    } insn_kind_t;

    // vd doubles as vs3 for stores
    typedef struct packed {
        insn_kind_t              kind;
        alu_op_t                 alu_op;
        logic                    use_imm;
        logic [REG_ADDR_W-1:0]   vd;
        logic [REG_ADDR_W-1:0]   vs1;
        logic [REG_ADDR_W-1:0]   vs2;
        logic [4:0]              imm5;
    } decoded_t;

    // src_a is vs1 data, src_b is vs2 data
    typedef struct packed {
        alu_op_t                 alu_op;
        logic                    use_imm;
        logic [4:0]              imm5;
        logic [REG_ADDR_W-1:0]   vd;
        logic [VLEN-1:0]         src_a;
        logic [VLEN-1:0]         src_b;
    } alu_req_t;

    typedef struct packed {
        logic                    valid;
        logic [REG_ADDR_W-1:0]   addr;
        logic [VLEN-1:0]         data;
    } wb_req_t;

endpackage

`default_nettype wire

/* insn_decode.sv */
`default_nettype none

module insn_decode (
    input  logic [vec_pkg::INSN_W-1:0] insn,
    output vec_pkg::decoded_t          dec
);
    import vec_pkg::*;

    logic [6:0] opc;
    logic [2:0] mnr;
    logic [5:0] funct6;
    logic [1:0] mop;

    // rvv field positions
    assign opc    = insn[6:0];
    assign mnr    = insn[14:12];
    assign mop    = insn[27:26];
    assign funct6 = insn[31:26];

    always_comb begin
        dec.kind    = KIND_NONE;
        dec.alu_op  = ALU_ADD;
        dec.use_imm = (mnr == MNR_VI);
        dec.vd      = insn[11:7];
        dec.vs1     = insn[19:15];
        dec.vs2     = insn[24:20];
        // imm5 sits in the vs1 slot
        dec.imm5    = insn[19:15];

        case (opc)
            // unit stride only
            OPC_LOAD:  if (mop == 2'b00) dec.kind = KIND_LOAD;
            OPC_STORE: if (mop == 2'b00) dec.kind = KIND_STORE;
            OPC_VALU: begin
                if (mnr == MNR_VV || mnr == MNR_VI) begin
                    dec.kind = KIND_ALU;
                    case (funct6)
                        F6_ADD: dec.alu_op = ALU_ADD;
                        F6_SUB: begin
                            dec.alu_op = ALU_SUB;
                            // no vsub.vi in the spec
                            if (mnr != MNR_VV) dec.kind = KIND_NONE;
                        end
                        F6_AND: dec.alu_op = ALU_AND;
                        F6_OR:  dec.alu_op = ALU_OR;
                        F6_XOR: dec.alu_op = ALU_XOR;
                        default: dec.kind = KIND_NONE;
                    endcase
                end
            end
            default: dec.kind = KIND_NONE;
        endcase
    end

endmodule

`default_nettype wire

/* hazard_scoreboard.sv */
`default_nettype none

module hazard_scoreboard (
    input  logic              clk,
    input  logic              rst_n,
    input  vec_pkg::decoded_t dec,
    input  logic              issue,
    input  vec_pkg::wb_req_t  wb,
    input  logic              mem_busy,
    output logic              stall
);
    import vec_pkg::*;

    logic [NUM_VEC-1:0] pending;
    logic [NUM_VEC-1:0] set_mask;
    logic [NUM_VEC-1:0] clr_mask;
    logic               use_vs1;
    logic               use_vs2;
    logic               use_vs3;
    logic               writes_vd;
    logic               is_mem;

    // operand usage per kind
    assign use_vs1   = (dec.kind == KIND_ALU) && !dec.use_imm;
    assign use_vs2   = (dec.kind == KIND_ALU);
    assign use_vs3   = (dec.kind == KIND_STORE);
    assign writes_vd = (dec.kind == KIND_ALU) || (dec.kind == KIND_LOAD);
    assign is_mem    = (dec.kind == KIND_LOAD) || (dec.kind == KIND_STORE);

    // raw on sources, waw on dest, single memory slot
    assign stall = (use_vs1 && pending[dec.vs1])
                 || (use_vs2 && pending[dec.vs2])
                 || (use_vs3 && pending[dec.vd])
                 || (writes_vd && pending[dec.vd])
                 || (is_mem && mem_busy);

    assign set_mask = (issue && writes_vd) ? (NUM_VEC'(1) << dec.vd) : '0;
    assign clr_mask = wb.valid ? (NUM_VEC'(1) << wb.addr) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clr_mask) | set_mask;
        end
    end

    // every writeback must belong to an issued instruction
    a_wb_was_pending: assert property (@(posedge clk) disable iff (!rst_n)
        wb.valid |-> pending[wb.addr]);

endmodule

`default_nettype wire

/* vec_regfile.sv */
`default_nettype none

module vec_regfile (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [vec_pkg::REG_ADDR_W-1:0] rd_addr_a,
    input  logic [vec_pkg::REG_ADDR_W-1:0] rd_addr_b,
    output logic [vec_pkg::VLEN-1:0]       rd_data_a,
    output logic [vec_pkg::VLEN-1:0]       rd_data_b,
    input  vec_pkg::wb_req_t               wb
);
    import vec_pkg::*;

    logic [VLEN-1:0] regs [NUM_VEC];

    // async read, no bypass
    // scoreboard holds readers until the write has landed
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_VEC; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.addr] <= wb.data;
        end
    end

endmodule

`default_nettype wire

/* valu_pipe.sv */
`default_nettype none

module valu_pipe (
    input  logic              clk,
    input  logic              rst_n,
    input  vec_pkg::alu_req_t req,
    input  logic              req_valid,
    output vec_pkg::wb_req_t  res
);
    import vec_pkg::*;

    logic [VLEN-1:0]                   imm_bcast;
    logic                              s1_valid;
    alu_op_t                           s1_op;
    logic [REG_ADDR_W-1:0]             s1_vd;
    logic [VLEN-1:0]                   s1_a;
    logic [VLEN-1:0]                   s1_b;
    logic [NUM_LANES-1:0][ELEM_W-1:0]  lane_a;
    logic [NUM_LANES-1:0][ELEM_W-1:0]  lane_b;
    logic [NUM_LANES-1:0][ELEM_W-1:0]  lane_res;

    // sign extend imm5 to one element, copy to every lane
    assign imm_bcast = {NUM_LANES{{{(ELEM_W-5){req.imm5[4]}}, req.imm5}}};

    // stage one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
        end
        s1_op <= req.alu_op;
        s1_vd <= req.vd;
        s1_a  <= req.use_imm ? imm_bcast : req.src_a;
        s1_b  <= req.src_b;
    end

    assign lane_a = s1_a;
    assign lane_b = s1_b;

    // lanes independent, 16 bit wrap
    // vd = vs2 op vs1
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            case (s1_op)
                ALU_ADD: lane_res[i] = lane_b[i] + lane_a[i];
                ALU_SUB: lane_res[i] = lane_b[i] - lane_a[i];
                ALU_AND: lane_res[i] = lane_b[i] & lane_a[i];
                ALU_OR:  lane_res[i] = lane_b[i] | lane_a[i];
                ALU_XOR: lane_res[i] = lane_b[i] ^ lane_a[i];
                default: lane_res[i] = '0;
            endcase
        end
    end

    // stage two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= s1_valid;
        end
        res.addr <= s1_vd;
        res.data <= lane_res;
    end

endmodule

`default_nettype wire

/* mem_pipe.sv */
`default_nettype none

module mem_pipe (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start_load,
    input  logic                           start_store,
    input  logic [vec_pkg::REG_ADDR_W-1:0] vd,
    input  logic [vec_pkg::VLEN-1:0]       st_data,
    input  logic [vec_pkg::VLEN-1:0]       mem_port_in,
    input  logic                           mem_port_valid_in,
    output logic                           mem_port_ready_out,
    output logic [vec_pkg::VLEN-1:0]       mem_port_out,
    output logic [vec_pkg::REG_ADDR_W-1:0] mem_port_addr_out,
    output logic                           mem_port_valid_out,
    input  logic                           hold_full,
    output vec_pkg::wb_req_t               ld_res,
    output logic                           busy
);
    import vec_pkg::*;

    logic                  ld_wait;
    logic [REG_ADDR_W-1:0] ld_vd;
    logic                  ld_take;

    // no ready while wb_merge still parks an older load
    assign mem_port_ready_out = ld_wait && !hold_full;
    assign ld_take            = mem_port_ready_out && mem_port_valid_in;

    // a store pulse counts as busy, keeps pulses apart
    assign busy = ld_wait || mem_port_valid_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_port_valid_out <= 1'b0;
            ld_wait            <= 1'b0;
            ld_res.valid       <= 1'b0;
        end else begin
            mem_port_valid_out <= start_store;
            ld_res.valid       <= ld_take;
            if (start_load) begin
                ld_wait <= 1'b1;
            end else if (ld_take) begin
                ld_wait <= 1'b0;
            end
        end
        ld_res.addr <= ld_vd;
        ld_res.data <= mem_port_in;
    end

    // store data and tag, address is just vs3
    always_ff @(posedge clk) begin
        if (start_store) begin
            mem_port_out      <= st_data;
            mem_port_addr_out <= vd;
        end
        if (start_load) begin
            ld_vd <= vd;
        end
    end

    a_store_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        mem_port_valid_out |=> !mem_port_valid_out);

endmodule

`default_nettype wire

/* wb_merge.sv */
`default_nettype none

module wb_merge (
    input  logic             clk,
    input  logic             rst_n,
    input  vec_pkg::wb_req_t alu_res,
    input  vec_pkg::wb_req_t ld_res,
    output vec_pkg::wb_req_t wb,
    output logic             hold_full
);
    import vec_pkg::*;

    wb_req_t hold_buf;

    assign hold_full = hold_buf.valid;

    // alu first, then parked load, then fresh load
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.valid       <= 1'b0;
            hold_buf.valid <= 1'b0;
        end else if (alu_res.valid) begin
            wb <= alu_res;
            // collision, park the load
            if (ld_res.valid) begin
                hold_buf <= ld_res;
            end
        end else if (hold_buf.valid) begin
            wb             <= hold_buf;
            hold_buf.valid <= 1'b0;
        end else begin
            wb <= ld_res;
        end
    end

    // mem_pipe drops ready while the buffer is occupied
    a_no_load_on_full: assert property (@(posedge clk) disable iff (!rst_n)
        ld_res.valid |-> !hold_buf.valid);

endmodule

`default_nettype wire

/* rvv_lane_top.sv */
`default_nettype none

module rvv_lane_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [vec_pkg::INSN_W-1:0]     insn_in,
    input  logic                           insn_valid,
    output logic                           proc_rdy,
    input  logic [vec_pkg::VLEN-1:0]       mem_port_in,
    input  logic                           mem_port_valid_in,
    output logic                           mem_port_ready_out,
    output logic [vec_pkg::VLEN-1:0]       mem_port_out,
    output logic [vec_pkg::REG_ADDR_W-1:0] mem_port_addr_out,
    output logic                           mem_port_valid_out
);
    import vec_pkg::*;

    logic [INSN_W-1:0]     cap_insn;
    logic                  cap_valid;
    logic                  rdy_q;
    decoded_t              dec;
    logic                  stall;
    logic                  issue;
    logic                  mem_busy;
    logic                  hold_full;
    logic [REG_ADDR_W-1:0] rd_addr_b;
    logic [VLEN-1:0]       rd_data_a;
    logic [VLEN-1:0]       rd_data_b;
    alu_req_t              alu_req;
    wb_req_t               alu_res;
    wb_req_t               ld_res;
    wb_req_t               wb;

    // rdy_q keeps proc_rdy low through reset
    assign proc_rdy = rdy_q && !(cap_valid && stall);
    // kind none issues too, dropped as a bubble
    assign issue    = cap_valid && !stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdy_q     <= 1'b0;
            cap_valid <= 1'b0;
        end else begin
            rdy_q <= 1'b1;
            if (proc_rdy) cap_valid <= insn_valid;
        end
    end

    // capture holds while stalled
    always_ff @(posedge clk) begin
        if (proc_rdy) cap_insn <= insn_in;
    end

    insn_decode u_dec (.insn(cap_insn), .dec(dec));

    hazard_scoreboard u_sb (
        .clk(clk), .rst_n(rst_n), .dec(dec), .issue(issue),
        .wb(wb), .mem_busy(mem_busy), .stall(stall)
    );

    // port b reads vs3 for stores
    assign rd_addr_b = (dec.kind == KIND_STORE) ? dec.vd : dec.vs2;

    vec_regfile u_rf (
        .clk(clk), .rst_n(rst_n), .rd_addr_a(dec.vs1), .rd_addr_b(rd_addr_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .wb(wb)
    );

    always_comb begin
        alu_req.alu_op  = dec.alu_op;
        alu_req.use_imm = dec.use_imm;
        alu_req.imm5    = dec.imm5;
        alu_req.vd      = dec.vd;
        alu_req.src_a   = rd_data_a;
        alu_req.src_b   = rd_data_b;
    end

    valu_pipe u_alu (
        .clk(clk), .rst_n(rst_n), .req(alu_req),
        .req_valid(issue && dec.kind == KIND_ALU), .res(alu_res)
    );

    mem_pipe u_mem (
        .clk(clk), .rst_n(rst_n),
        .start_load(issue && dec.kind == KIND_LOAD),
        .start_store(issue && dec.kind == KIND_STORE),
        .vd(dec.vd), .st_data(rd_data_b),
        .mem_port_in(mem_port_in), .mem_port_valid_in(mem_port_valid_in),
        .mem_port_ready_out(mem_port_ready_out), .mem_port_out(mem_port_out),
        .mem_port_addr_out(mem_port_addr_out), .mem_port_valid_out(mem_port_valid_out),
        .hold_full(hold_full), .ld_res(ld_res), .busy(mem_busy)
    );

    wb_merge u_wb (
        .clk(clk), .rst_n(rst_n), .alu_res(alu_res), .ld_res(ld_res),
        .wb(wb), .hold_full(hold_full)
    );

endmodule

`default_nettype wire

/* tb_checker.sv */
`default_nettype none

module tb_checker (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [vec_pkg::INSN_W-1:0]     insn_in,
    input  logic                           insn_valid,
    input  logic                           proc_rdy,
    input  logic [vec_pkg::VLEN-1:0]       mem_port_in,
    input  logic                           mem_port_valid_in,
    input  logic                           mem_port_ready_out,
    input  logic [vec_pkg::VLEN-1:0]       mem_port_out,
    input  logic [vec_pkg::REG_ADDR_W-1:0] mem_port_addr_out,
    input  logic                           mem_port_valid_out,
    output int                             errors,
    output int                             stores_seen,
    output int                             outstanding
);
    timeunit 1ns;
    timeprecision 100ps;

    import vec_pkg::*;

    logic [VLEN-1:0]   model [NUM_VEC];
    logic [INSN_W-1:0] pend_q [$];
    bit                rst_seen = 1'b0;

    function automatic bit is_load(logic [31:0] w);
        return (w[6:0] == 7'h07) && (w[27:26] == 2'b00);
    endfunction

    function automatic bit is_store(logic [31:0] w);
        return (w[6:0] == 7'h27) && (w[27:26] == 2'b00);
    endfunction

    function automatic bit is_alu(logic [31:0] w);
        logic [5:0] f6;
        logic [2:0] f3;
        f6 = w[31:26];
        f3 = w[14:12];
        if (w[6:0] != 7'h57) return 1'b0;
        if (f3 == 3'd0) return f6 inside {6'h00, 6'h02, 6'h09, 6'h0A, 6'h0B};
        // immediate form has no sub
        if (f3 == 3'd3) return f6 inside {6'h00, 6'h09, 6'h0A, 6'h0B};
        return 1'b0;
    endfunction

    // vd = vs2 op (vs1 or broadcast imm), per 16 bit lane
    function automatic logic [VLEN-1:0] alu_model(logic [31:0] w);
        logic [ELEM_W-1:0] a;
        logic [ELEM_W-1:0] b;
        logic [ELEM_W-1:0] r;
        logic [VLEN-1:0]   res;
        res = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            b = ELEM_W'(model[w[24:20]] >> (ELEM_W * l));
            if (w[14:12] == 3'd3)
                a = {{(ELEM_W - 5){w[19]}}, w[19:15]};
            else
                a = ELEM_W'(model[w[19:15]] >> (ELEM_W * l));
            case (w[31:26])
                6'h00:   r = b + a;
                6'h02:   r = b - a;
                6'h09:   r = b & a;
                6'h0A:   r = b | a;
                default: r = b ^ a;
            endcase
            res = res | (VLEN'(r) << (ELEM_W * l));
        end
        return res;
    endfunction

    // alu ops and bubbles retire in order up to the next memory op
    task automatic retire_alu_ops();
        logic [31:0] w;
        while (pend_q.size() > 0 && !is_load(pend_q[0]) && !is_store(pend_q[0])) begin
            w = pend_q.pop_front();
            if (is_alu(w)) model[w[11:7]] = alu_model(w);
        end
    endtask

    task automatic take_load();
        logic [31:0] w;
        if (pend_q.size() == 0 || !is_load(pend_q[0])) begin
            $display("Error: load data accepted with no load waiting at %0t", $time);
            errors++;
        end else begin
            w = pend_q.pop_front();
            model[w[11:7]] = mem_port_in;
        end
    endtask

    task automatic check_store();
        logic [31:0]     w;
        logic [VLEN-1:0] exp_data;
        if (pend_q.size() == 0 || !is_store(pend_q[0])) begin
            $display("Error: store pulse with no store instruction waiting at %0t", $time);
            errors++;
        end else begin
            w = pend_q.pop_front();
            exp_data = model[w[11:7]];
            stores_seen++;
            if (mem_port_out !== exp_data) begin
                $display("Mismatch mem_port_out: vs3 %0d expected %h got %h",
                         w[11:7], exp_data, mem_port_out);
                errors++;
            end
            if (mem_port_addr_out !== w[11:7]) begin
                $display("Mismatch mem_port_addr_out: expected %h got %h",
                         w[11:7], mem_port_addr_out);
                errors++;
            end
        end
    endtask

    // mid-cycle sampling, everything stable here
    always @(negedge clk) begin
        if (!rst_n) begin
            if (rst_seen && (proc_rdy !== 1'b0 || mem_port_valid_out !== 1'b0
                             || mem_port_ready_out !== 1'b0)) begin
                $display("Error: lane outputs not idle during reset at %0t", $time);
                errors++;
            end
            rst_seen = 1'b1;
            model = '{default: '0};
            pend_q.delete();
        end else begin
            retire_alu_ops();
            if (mem_port_valid_in && mem_port_ready_out) take_load();
            if (mem_port_valid_out) check_store();
            // accepted on the coming edge
            if (insn_valid && proc_rdy) pend_q.push_back(insn_in);
        end
        outstanding = pend_q.size();
    end

endmodule

`default_nettype wire

/* tb_top.sv */
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    import vec_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 8;
    localparam int CYCLES_PER_INSN = 40;

    // funct6 values from the rvv spec
    localparam logic [5:0] OP_ADD = 6'h00;
    localparam logic [5:0] OP_SUB = 6'h02;
    localparam logic [5:0] OP_AND = 6'h09;
    localparam logic [5:0] OP_OR  = 6'h0A;
    localparam logic [5:0] OP_XOR = 6'h0B;

    logic                  clk = 1'b0;
    logic                  rst_n = 1'b0;
    logic [INSN_W-1:0]     insn_in = '0;
    logic                  insn_valid = 1'b0;
    logic [VLEN-1:0]       mem_port_in = '0;
    logic                  mem_port_valid_in = 1'b0;
    logic                  proc_rdy;
    logic                  mem_port_ready_out;
    logic [VLEN-1:0]       mem_port_out;
    logic [REG_ADDR_W-1:0] mem_port_addr_out;
    logic                  mem_port_valid_out;
    int                    errors;
    int                    stores_seen;
    int                    outstanding;

    logic [INSN_W-1:0]     prog [$];
    logic [VLEN-1:0]       ld_data [$];
    int                    ld_idx = 0;
    int                    wait_cnt = 2;
    integer                seed = 32'h9979d0ad;

    // vm=1 everywhere, unmasked
    function automatic logic [31:0] enc_vv(logic [5:0] f6, int vd, int vs2, int vs1);
        return {f6, 1'b1, 5'(vs2), 5'(vs1), 3'b000, 5'(vd), 7'h57};
    endfunction

    function automatic logic [31:0] enc_vi(logic [5:0] f6, int vd, int vs2, int imm);
        return {f6, 1'b1, 5'(vs2), 5'(imm), 3'b011, 5'(vd), 7'h57};
    endfunction

    // unit stride, eew16, rs1 = x0
    function automatic logic [31:0] enc_load(int vd);
        return {3'b000, 1'b0, 2'b00, 1'b1, 5'd0, 5'd0, 3'b101, 5'(vd), 7'h07};
    endfunction

    function automatic logic [31:0] enc_store(int vs3);
        return {3'b000, 1'b0, 2'b00, 1'b1, 5'd0, 5'd0, 3'b101, 5'(vs3), 7'h27};
    endfunction

    // past the table, a word that still tracks the index
    function automatic logic [VLEN-1:0] next_load_word(int idx);
        if (idx < ld_data.size()) begin
            return ld_data[idx];
        end
        return {2{32'(idx) * 32'h9e37_79b9}};
    endfunction

    always #(CLK_PERIOD / 2) clk = ~clk;

    rvv_lane_top u_dut (
        .clk(clk), .rst_n(rst_n),
        .insn_in(insn_in), .insn_valid(insn_valid), .proc_rdy(proc_rdy),
        .mem_port_in(mem_port_in), .mem_port_valid_in(mem_port_valid_in),
        .mem_port_ready_out(mem_port_ready_out), .mem_port_out(mem_port_out),
        .mem_port_addr_out(mem_port_addr_out), .mem_port_valid_out(mem_port_valid_out)
    );

    tb_checker u_chk (
        .clk(clk), .rst_n(rst_n),
        .insn_in(insn_in), .insn_valid(insn_valid), .proc_rdy(proc_rdy),
        .mem_port_in(mem_port_in), .mem_port_valid_in(mem_port_valid_in),
        .mem_port_ready_out(mem_port_ready_out), .mem_port_out(mem_port_out),
        .mem_port_addr_out(mem_port_addr_out), .mem_port_valid_out(mem_port_valid_out),
        .errors(errors), .stores_seen(stores_seen), .outstanding(outstanding)
    );

    // memory model, answers a waiting load after 0 to 3 cycles
    always @(negedge clk) begin
        if (rst_n && mem_port_valid_in && mem_port_ready_out) begin
            @(posedge clk);
            #1;
            mem_port_valid_in = 1'b0;
            ld_idx++;
            wait_cnt = $unsigned($random(seed)) % 4;
        end else if (rst_n && mem_port_ready_out && !mem_port_valid_in) begin
            if (wait_cnt == 0) begin
                @(posedge clk);
                #1;
                mem_port_in       = next_load_word(ld_idx);
                mem_port_valid_in = 1'b1;
            end else begin
                wait_cnt--;
            end
        end
    end

    initial begin
        int limit_ns;
        prog = '{
            // fill v1..v4, then store them back
            enc_load(1), enc_load(2), enc_load(3), enc_load(4),
            enc_store(1), enc_store(2), enc_store(3), enc_store(4),
            // vector-vector forms
            enc_vv(OP_ADD, 5, 2, 1), enc_vv(OP_SUB, 6, 1, 2),
            enc_vv(OP_AND, 7, 3, 4), enc_vv(OP_OR, 8, 3, 4),
            enc_vv(OP_XOR, 9, 1, 3),
            enc_store(5), enc_store(6), enc_store(7), enc_store(8), enc_store(9),
            // immediates of both signs
            enc_vi(OP_ADD, 10, 1, -3), enc_vi(OP_AND, 11, 2, 15),
            enc_vi(OP_OR, 12, 3, -16), enc_vi(OP_XOR, 13, 4, 5),
            enc_store(10), enc_store(11), enc_store(12), enc_store(13),
            // raw chain, waw on v15, store right behind the last write
            enc_vv(OP_ADD, 14, 5, 6), enc_vv(OP_SUB, 15, 14, 1),
            enc_vi(OP_ADD, 15, 15, 1), enc_store(15),
            // vsub.vi is not legal, v16 stays zero
            enc_vi(OP_SUB, 16, 1, 1), enc_store(16),
            // four alu results in a row cover every reply delay of the load
            enc_load(17), enc_vv(OP_ADD, 18, 1, 2), enc_vv(OP_OR, 20, 3, 4),
            enc_vv(OP_AND, 23, 2, 3), enc_vv(OP_SUB, 24, 4, 1),
            enc_load(19), enc_vi(OP_XOR, 25, 2, -7),
            enc_load(21), enc_vv(OP_XOR, 22, 18, 20),
            enc_store(17), enc_store(18), enc_store(19),
            enc_store(20), enc_store(21), enc_store(22),
            enc_store(23), enc_store(24), enc_store(25)
        };
        // lanes chosen to hit 16 bit wraparound
        ld_data = '{
            64'h7fff_8000_ffff_0001, 64'h0001_8000_0001_ffff,
            64'h1234_5678_9abc_def0, 64'h0f0f_f0f0_aaaa_5555,
            64'hcafe_0000_0000_beef, 64'h8001_7ffe_0010_fff0,
            64'h3c3c_c3c3_0102_fedc
        };
        limit_ns = (prog.size() * CYCLES_PER_INSN + RESET_CYCLES) * CLK_PERIOD;

        fork
            begin
                #(limit_ns);
                $display("Watchdog expired after %0d ns with %0d errors", limit_ns, errors);
                $display("Simulation failed");
                $finish;
            end
        join_none

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        // each word held until the lane takes it
        for (int i = 0; i < prog.size(); i++) begin
            insn_in    = prog[i];
            insn_valid = 1'b1;
            @(negedge clk);
            while (!proc_rdy) @(negedge clk);
            @(posedge clk);
            #1;
        end
        insn_valid = 1'b0;

        // let the last stores drain
        while (outstanding != 0) @(posedge clk);
        repeat (8) @(posedge clk);

        $display("Run done: %0d stores compared, %0d errors", stores_seen, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
vec_pkg.sv
insn_decode.sv
hazard_scoreboard.sv
vec_regfile.sv
valu_pipe.sv
mem_pipe.sv
wb_merge.sv
rvv_lane_top.sv
tb_checker.sv
tb_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= tb_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
